/* all.f */
dma_read_pkg.sv
sync_fifo.sv
tag_free_list.sv
req_issue.sv
cpl_collect.sv
rsp_return.sv
dma_read_top.sv
tb_dma_read_sva.sv
tb_dma_read.sv

/* cpl_collect.sv */
// per-tag chunk counting, completion data buffer and queue of finished reads
`timescale 1ns/100ps

module cpl_collect #(
   parameter int NUM_TAGS = 16,
   parameter int DATA_W   = 64
) (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_cpl_v,
   input  dma_read_pkg::tag_t    i_cpl_tag,
   input  logic [DATA_W-1:0]     i_cpl_data,
   input  logic                  i_cpl_last,
   input  logic                  i_cpl_err,
   output logic                  o_done_v,
   input  logic                  i_done_r,
   output dma_read_pkg::done_t   o_done,
   input  logic [dma_read_pkg::TAG_W+dma_read_pkg::BEAT_W-1:0] i_buf_ra,
   output logic [DATA_W-1:0]     o_buf_rd
);

   import dma_read_pkg::*;

   logic [BEAT_W-1:0]   cnt_q [NUM_TAGS];
   logic [NUM_TAGS-1:0] err_q;
   logic [BEAT_W-1:0]   cur_cnt;
   logic                cur_err;
   logic [DATA_W-1:0]   buf_mem [NUM_TAGS*MAX_CHUNKS];
   done_t               done_in;

   // chunks of one tag arrive in order, so the count is the slot within the tag
   assign cur_cnt = cnt_q[i_cpl_tag];
   assign cur_err = err_q[i_cpl_tag] | i_cpl_err;

   assign done_in.tag = i_cpl_tag;
   assign done_in.cnt = len_t'(cur_cnt) + len_t'(1);
   assign done_in.err = cur_err;

   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         err_q <= '0;
         for (int t = 0; t < NUM_TAGS; t++)
         begin
            cnt_q[t] <= '0;
         end
      end
      else if (i_cpl_v)
      begin
         // a last chunk leaves the tag clean for its next read
         if (i_cpl_last)
         begin
            cnt_q[i_cpl_tag] <= '0;
            err_q[i_cpl_tag] <= 1'b0;
         end
         else
         begin
            cnt_q[i_cpl_tag] <= cur_cnt + BEAT_W'(1);
            err_q[i_cpl_tag] <= cur_err;
         end
      end
   end

   always_ff @(posedge i_clk)
   begin
      if (i_cpl_v)
         buf_mem[{i_cpl_tag, cur_cnt}] <= i_cpl_data;
      o_buf_rd <= buf_mem[i_buf_ra];
   end

   // at most one finished read per tag can wait, so NUM_TAGS entries suffice
   sync_fifo #(
      .DEPTH (NUM_TAGS),
      .T     (done_t)
   ) done_fifo_inst (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (i_cpl_v & i_cpl_last),
      .i_din   (done_in),
      .o_full  (),
      .o_v     (o_done_v),
      .i_pop   (i_done_r),
      .o_dout  (o_done)
   );

endmodule

/* dma_read_pkg.sv */
// shared constants, scalar types and structs for the read DMA engine
package dma_read_pkg;

   localparam int TAG_W       = 4;
   localparam int ENG_TAG_W   = 4;
   localparam int ADDR_W      = 48;
   localparam int CHUNK_BYTES = 128;
   localparam int MAX_CHUNKS  = 4;
   // bits needed to number the chunks of one read
   localparam int BEAT_W      = $clog2(MAX_CHUNKS);

   typedef logic [TAG_W-1:0]     tag_t;
   typedef logic [ENG_TAG_W-1:0] eng_tag_t;
   typedef logic [ADDR_W-1:0]    addr_t;
   // read length in chunks, legal values 1 to MAX_CHUNKS
   typedef logic [2:0]           len_t;

   // what the requester asked for, kept per bus tag
   typedef struct packed {
      eng_tag_t eng_tag;
      len_t     len;
   } ctx_t;

   // one finished read waiting to be returned
   typedef struct packed {
      tag_t tag;
      len_t cnt;
      logic err;
   } done_t;

endpackage

/* dma_read_top.sv */
// read DMA engine top level with tag pool, issue, collect and return blocks
`timescale 1ns/100ps

module dma_read_top #(
   parameter int NUM_TAGS = 16,
   parameter int DATA_W   = 64
) (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic                   i_req_v,
   output logic                   o_req_r,
   input  dma_read_pkg::eng_tag_t i_req_eng_tag,
   input  dma_read_pkg::addr_t    i_req_addr,
   input  dma_read_pkg::len_t     i_req_len,
   output logic                   o_cmd_v,
   input  logic                   i_cmd_r,
   output dma_read_pkg::tag_t     o_cmd_tag,
   output dma_read_pkg::addr_t    o_cmd_addr,
   output dma_read_pkg::len_t     o_cmd_len,
   input  logic                   i_cpl_v,
   input  dma_read_pkg::tag_t     i_cpl_tag,
   input  logic [DATA_W-1:0]      i_cpl_data,
   input  logic                   i_cpl_last,
   input  logic                   i_cpl_err,
   output logic                   o_rsp_v,
   output dma_read_pkg::eng_tag_t o_rsp_eng_tag,
   output logic [dma_read_pkg::BEAT_W-1:0] o_rsp_beat,
   output logic [DATA_W-1:0]      o_rsp_data,
   output logic                   o_rsp_last,
   output logic                   o_rsp_err,
   input  logic                   i_rsp_r
);

   import dma_read_pkg::*;

   logic                    tag_v;
   logic                    tag_r;
   tag_t                    tag;
   logic                    free_v;
   tag_t                    free_tag;
   tag_t                    ctx_ra;
   ctx_t                    ctx_rd;
   logic                    done_v;
   logic                    done_r;
   done_t                   done;
   logic [TAG_W+BEAT_W-1:0] buf_ra;
   logic [DATA_W-1:0]       buf_rd;

   tag_free_list #(
      .NUM_TAGS (NUM_TAGS)
   ) tag_free_list_inst (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .o_tag_v    (tag_v),
      .i_tag_r    (tag_r),
      .o_tag      (tag),
      .i_free_v   (free_v),
      .i_free_tag (free_tag)
   );

   req_issue #(
      .NUM_TAGS (NUM_TAGS)
   ) req_issue_inst (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_req_v       (i_req_v),
      .o_req_r       (o_req_r),
      .i_req_eng_tag (i_req_eng_tag),
      .i_req_addr    (i_req_addr),
      .i_req_len     (i_req_len),
      .i_tag_v       (tag_v),
      .o_tag_r       (tag_r),
      .i_tag         (tag),
      .o_cmd_v       (o_cmd_v),
      .i_cmd_r       (i_cmd_r),
      .o_cmd_tag     (o_cmd_tag),
      .o_cmd_addr    (o_cmd_addr),
      .o_cmd_len     (o_cmd_len),
      .i_ctx_ra      (ctx_ra),
      .o_ctx_rd      (ctx_rd)
   );

   cpl_collect #(
      .NUM_TAGS (NUM_TAGS),
      .DATA_W   (DATA_W)
   ) cpl_collect_inst (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_cpl_v    (i_cpl_v),
      .i_cpl_tag  (i_cpl_tag),
      .i_cpl_data (i_cpl_data),
      .i_cpl_last (i_cpl_last),
      .i_cpl_err  (i_cpl_err),
      .o_done_v   (done_v),
      .i_done_r   (done_r),
      .o_done     (done),
      .i_buf_ra   (buf_ra),
      .o_buf_rd   (buf_rd)
   );

   rsp_return #(
      .NUM_TAGS (NUM_TAGS),
      .DATA_W   (DATA_W)
   ) rsp_return_inst (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_done_v      (done_v),
      .o_done_r      (done_r),
      .i_done        (done),
      .o_ctx_ra      (ctx_ra),
      .i_ctx_rd      (ctx_rd),
      .o_buf_ra      (buf_ra),
      .i_buf_rd      (buf_rd),
      .o_rsp_v       (o_rsp_v),
      .o_rsp_eng_tag (o_rsp_eng_tag),
      .o_rsp_beat    (o_rsp_beat),
      .o_rsp_data    (o_rsp_data),
      .o_rsp_last    (o_rsp_last),
      .o_rsp_err     (o_rsp_err),
      .i_rsp_r       (i_rsp_r),
      .o_free_v      (free_v),
      .o_free_tag    (free_tag)
   );

endmodule

/* req_issue.sv */
// request and free-tag join, address alignment, command issue and per-tag context
`timescale 1ns/100ps

module req_issue #(
   parameter int NUM_TAGS = 16
) (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic                   i_req_v,
   output logic                   o_req_r,
   input  dma_read_pkg::eng_tag_t i_req_eng_tag,
   input  dma_read_pkg::addr_t    i_req_addr,
   input  dma_read_pkg::len_t     i_req_len,
   input  logic                   i_tag_v,
   output logic                   o_tag_r,
   input  dma_read_pkg::tag_t     i_tag,
   output logic                   o_cmd_v,
   input  logic                   i_cmd_r,
   output dma_read_pkg::tag_t     o_cmd_tag,
   output dma_read_pkg::addr_t    o_cmd_addr,
   output dma_read_pkg::len_t     o_cmd_len,
   input  dma_read_pkg::tag_t     i_ctx_ra,
   output dma_read_pkg::ctx_t     o_ctx_rd
);

   import dma_read_pkg::*;

   // low address bits cleared for a single chunk and for a full read
   localparam int LO_SHORT = $clog2(CHUNK_BYTES);
   localparam int LO_LONG  = $clog2(CHUNK_BYTES * MAX_CHUNKS);

   ctx_t ctx_mem [NUM_TAGS];
   logic issue;

   // request, tag and command all complete in the same cycle
   assign o_cmd_v = i_req_v & i_tag_v;
   assign o_req_r = i_tag_v & i_cmd_r;
   assign o_tag_r = i_req_v & i_cmd_r;
   assign issue   = i_req_v & i_tag_v & i_cmd_r;

   assign o_cmd_tag  = i_tag;
   assign o_cmd_len  = i_req_len;
   assign o_cmd_addr = (i_req_len == len_t'(1)) ?
                       {i_req_addr[ADDR_W-1:LO_SHORT], {LO_SHORT{1'b0}}} :
                       {i_req_addr[ADDR_W-1:LO_LONG], {LO_LONG{1'b0}}};

   always_ff @(posedge i_clk)
   begin
      if (issue)
      begin
         ctx_mem[i_tag].eng_tag <= i_req_eng_tag;
         ctx_mem[i_tag].len     <= i_req_len;
      end
      o_ctx_rd <= ctx_mem[i_ctx_ra];
   end

endmodule

/* rsp_return.sv */
// response FSM that streams finished reads out of the buffer and frees their tags
`timescale 1ns/100ps

module rsp_return #(
   parameter int NUM_TAGS = 16,
   parameter int DATA_W   = 64
) (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic                   i_done_v,
   output logic                   o_done_r,
   input  dma_read_pkg::done_t    i_done,
   output dma_read_pkg::tag_t     o_ctx_ra,
   input  dma_read_pkg::ctx_t     i_ctx_rd,
   output logic [dma_read_pkg::TAG_W+dma_read_pkg::BEAT_W-1:0] o_buf_ra,
   input  logic [DATA_W-1:0]      i_buf_rd,
   output logic                   o_rsp_v,
   output dma_read_pkg::eng_tag_t o_rsp_eng_tag,
   output logic [dma_read_pkg::BEAT_W-1:0] o_rsp_beat,
   output logic [DATA_W-1:0]      o_rsp_data,
   output logic                   o_rsp_last,
   output logic                   o_rsp_err,
   input  logic                   i_rsp_r,
   output logic                   o_free_v,
   output dma_read_pkg::tag_t     o_free_tag
);

   import dma_read_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FETCH,
      ST_SEND
   } state_t;

   state_t            state_q;
   tag_t              cur_tag;
   len_t              cur_cnt;
   logic              cur_err;
   logic [BEAT_W-1:0] beat_q;
   logic [BEAT_W-1:0] rd_beat;
   logic              last_beat;
   logic              len_err;

   assign o_done_r = (state_q == ST_IDLE);

   // the context read address stays on the current tag so i_ctx_rd holds all read long
   assign o_ctx_ra = (state_q == ST_IDLE) ? i_done.tag : cur_tag;

   // while a beat is presented the buffer already reads the next one
   assign rd_beat  = (state_q == ST_SEND) ? beat_q + BEAT_W'(1) : beat_q;
   assign o_buf_ra = {o_ctx_ra, rd_beat};

   assign last_beat = (len_t'(beat_q) == i_ctx_rd.len - len_t'(1));
   // a read that got fewer or more chunks than requested is reported as an error
   assign len_err   = (cur_cnt != i_ctx_rd.len);

   assign o_free_tag = cur_tag;

   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         state_q  <= ST_IDLE;
         beat_q   <= '0;
         o_rsp_v  <= 1'b0;
         o_free_v <= 1'b0;
      end
      else
      begin
         o_free_v <= 1'b0;
         case (state_q)
            ST_IDLE:
            begin
               if (i_done_v)
                  state_q <= ST_FETCH;
            end
            ST_FETCH:
            begin
               o_rsp_v <= 1'b1;
               state_q <= ST_SEND;
            end
            ST_SEND:
            begin
               if (i_rsp_r)
               begin
                  o_rsp_v <= 1'b0;
                  if (o_rsp_last)
                  begin
                     beat_q   <= '0;
                     o_free_v <= 1'b1;
                     state_q  <= ST_IDLE;
                  end
                  else
                  begin
                     beat_q  <= beat_q + BEAT_W'(1);
                     state_q <= ST_FETCH;
                  end
               end
            end
            default:
            begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge i_clk)
   begin
      if (state_q == ST_IDLE && i_done_v)
      begin
         cur_tag <= i_done.tag;
         cur_cnt <= i_done.cnt;
         cur_err <= i_done.err;
      end
      // output register loads only in FETCH, so it holds while the consumer stalls
      if (state_q == ST_FETCH)
      begin
         o_rsp_eng_tag <= i_ctx_rd.eng_tag;
         o_rsp_beat    <= beat_q;
         o_rsp_data    <= i_buf_rd;
         o_rsp_last    <= last_beat;
         o_rsp_err     <= last_beat & (cur_err | len_err);
      end
   end

endmodule

/* run.sh */
#!/bin/sh
# build and run the read DMA testbench with Verilator
verilator --binary --timing --assert --top-module tb_dma_read -f all.f -o sim_dma_read
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi
out=$(./obj_dir/sim_dma_read)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
   echo "simulation exited with status $rc"
   exit 1
fi
if printf '%s\n' "$out" | grep -qx 'STATUS: PASS'; then
   exit 0
fi
exit 1

/* sync_fifo.sv */
// single-clock FIFO with a type-parameterised payload
`timescale 1ns/100ps

module sync_fifo #(
   parameter int  DEPTH = 16,
   parameter type T     = logic
) (
   input  logic i_clk,
   input  logic i_rst_n,
   input  logic i_push,
   input  T     i_din,
   output logic o_full,
   output logic o_v,
   input  logic i_pop,
   output T     o_dout
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   T               mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             do_push;
   logic             do_pop;

   assign o_full  = (count == (PTR_W+1)'(DEPTH));
   assign o_v     = (count != '0);
   assign o_dout  = mem[rd_ptr];
   assign do_push = i_push & ~o_full;
   assign do_pop  = i_pop & o_v;

   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         // pointers wrap at DEPTH so any depth works
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + PTR_W'(1);
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + PTR_W'(1);
         if (do_push && !do_pop)
            count <= count + (PTR_W+1)'(1);
         else if (do_pop && !do_push)
            count <= count - (PTR_W+1)'(1);
      end
   end

   always_ff @(posedge i_clk)
   begin
      if (do_push)
         mem[wr_ptr] <= i_din;
   end

endmodule

/* tag_free_list.sv */
// pool of free bus tags, loaded with every tag after reset
`timescale 1ns/100ps

module tag_free_list #(
   parameter int NUM_TAGS = 16
) (
   input  logic               i_clk,
   input  logic               i_rst_n,
   output logic               o_tag_v,
   input  logic               i_tag_r,
   output dma_read_pkg::tag_t o_tag,
   input  logic               i_free_v,
   input  dma_read_pkg::tag_t i_free_tag
);

   import dma_read_pkg::*;

   logic [TAG_W:0] init_cnt;
   logic           init_done;
   logic           push;
   tag_t           push_tag;
   logic           fifo_v;

   assign init_done = (init_cnt == (TAG_W+1)'(NUM_TAGS));
   // the init counter owns the push side until every tag has been loaded
   assign push      = ~init_done | i_free_v;
   assign push_tag  = init_done ? i_free_tag : init_cnt[TAG_W-1:0];
   assign o_tag_v   = init_done & fifo_v;

   always_ff @(posedge i_clk)
   begin
      if (!i_rst_n)
         init_cnt <= '0;
      else if (!init_done)
         init_cnt <= init_cnt + (TAG_W+1)'(1);
   end

   sync_fifo #(
      .DEPTH (NUM_TAGS),
      .T     (tag_t)
   ) tag_fifo_inst (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (push),
      .i_din   (push_tag),
      .o_full  (),
      .o_v     (fifo_v),
      .i_pop   (o_tag_v & i_tag_r),
      .o_dout  (o_tag)
   );

endmodule

/* tb_dma_read.sv */
// testbench for the read DMA engine with a bus responder model,
// a reference function for the expected beats, a beat checker and a timeout
`timescale 1ns/100ps

module tb_dma_read;

   import dma_read_pkg::*;

   localparam int NUM_TAGS  = 16;
   localparam int DATA_W    = 64;
   localparam int MAX_READS = 128;
   // reads over all tests, and a generous cycle bound for each of them
   localparam int TOTAL_READS = 100;
   localparam int TIMEOUT_CYC = TOTAL_READS * 60 + 100;

   typedef struct packed {
      eng_tag_t          eng_tag;
      logic [BEAT_W-1:0] beat;
      logic [DATA_W-1:0] data;
      logic              last;
      logic              err;
   } beat_t;

   logic                i_clk;
   logic                i_rst_n;
   logic                i_req_v;
   logic                o_req_r;
   eng_tag_t            i_req_eng_tag;
   addr_t               i_req_addr;
   len_t                i_req_len;
   logic                o_cmd_v;
   logic                i_cmd_r;
   tag_t                o_cmd_tag;
   addr_t               o_cmd_addr;
   len_t                o_cmd_len;
   logic                i_cpl_v;
   tag_t                i_cpl_tag;
   logic [DATA_W-1:0]   i_cpl_data;
   logic                i_cpl_last;
   logic                i_cpl_err;
   logic                o_rsp_v;
   eng_tag_t            o_rsp_eng_tag;
   logic [BEAT_W-1:0]   o_rsp_beat;
   logic [DATA_W-1:0]   o_rsp_data;
   logic                o_rsp_last;
   logic                o_rsp_err;
   logic                i_rsp_r;

   // what the bus model recorded for each read
   eng_tag_t            rd_eng [MAX_READS];
   len_t                rd_len [MAX_READS];
   tag_t                rd_tag [MAX_READS];
   int                  rd_sent [MAX_READS];
   logic [DATA_W-1:0]   rd_data [MAX_READS][MAX_CHUNKS];
   logic [MAX_CHUNKS-1:0] rd_err [MAX_READS];
   logic [NUM_TAGS-1:0] tag_busy;
   int                  act[$];
   int                  exp_order[$];

   logic [15:0] lfsr_q = 16'd539;
   int          err_cnt = 0;
   int          check_cnt = 0;
   int          done_cnt = 0;
   int          issued_tot = 0;
   int          freed_cnt = 0;
   int          freed_d1 = 0;
   int          freed_d2 = 0;
   int          beat_idx = 0;
   int          cycle_cnt = 0;
   int          test_cnt = 0;

   dma_read_top #(
      .NUM_TAGS (NUM_TAGS),
      .DATA_W   (DATA_W)
   ) dma_read_top_inst (.*);

   initial
   begin
      i_clk = 1'b0;
      forever #20 i_clk = ~i_clk;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // one LFSR step for every bit taken
   function logic [63:0] take_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[62:0], lfsr_q[0]};
      end
      return v;
   endfunction

   function automatic addr_t aligned_addr(input addr_t a, input len_t l);
      return (l == 3'd1) ? {a[ADDR_W-1:7], 7'd0} : {a[ADDR_W-1:9], 9'd0};
   endfunction

   // expected beat of a read, built from the command and the chunks the bus sent
   function automatic beat_t expect_beat(input int rid, input int beat);
      beat_t b;
      logic  any_err;
      any_err = 1'b0;
      for (int i = 0; i < int'(rd_len[rid]); i++)
      begin
         any_err = any_err | rd_err[rid][i];
      end
      b.eng_tag = rd_eng[rid];
      b.beat    = beat[BEAT_W-1:0];
      b.data    = rd_data[rid][beat];
      b.last    = (beat == int'(rd_len[rid]) - 1);
      b.err     = b.last & any_err;
      return b;
   endfunction

   task automatic report_value(input string sig, input logic [63:0] got,
                               input logic [63:0] exp);
      $display("[FAIL] %s got %h expected %h", sig, got, exp);
      err_cnt++;
   endtask

   task automatic record_command(input bit err_en);
      int          rid;
      logic [63:0] r;
      rid = issued_tot;
      check_cnt++;
      if (!o_cmd_v)
      begin
         $display("request accepted while no command was offered");
         err_cnt++;
      end
      if (o_cmd_len !== i_req_len)
         report_value("o_cmd_len", 64'(o_cmd_len), 64'(i_req_len));
      if (o_cmd_addr !== aligned_addr(i_req_addr, i_req_len))
         report_value("o_cmd_addr", 64'(o_cmd_addr), 64'(aligned_addr(i_req_addr, i_req_len)));
      if (tag_busy[o_cmd_tag])
      begin
         $display("bus tag %0d issued while still in use", o_cmd_tag);
         err_cnt++;
      end
      rd_eng[rid]  = i_req_eng_tag;
      rd_len[rid]  = i_req_len;
      rd_tag[rid]  = o_cmd_tag;
      rd_sent[rid] = 0;
      for (int i = 0; i < MAX_CHUNKS; i++)
      begin
         rd_data[rid][i] = take_bits(64);
         r = take_bits(3);
         rd_err[rid][i] = err_en & (r[2:0] == 3'd0);
      end
      tag_busy[o_cmd_tag] = 1'b1;
      act.push_back(rid);
      issued_tot++;
   endtask

   task automatic run_test(input string name, input int n, input bit fixed_len,
                           input bit err_en, input bit stall_en, input bit hold_cpl,
                           input bit mix, input bit reuse_chk);
      int          gen;
      int          target;
      int          start_err;
      int          idx;
      int          rid;
      bit          pending;
      logic [63:0] r;
      gen       = 0;
      pending   = 0;
      target    = done_cnt + n;
      start_err = err_cnt;
      freed_d1  = freed_cnt;
      freed_d2  = freed_cnt;
      while (done_cnt < target)
      begin
         @(posedge i_clk);
         // a tag is back in the pool two edges after its last beat
         freed_d2 = freed_d1;
         freed_d1 = freed_cnt;
         if (reuse_chk && i_cmd_r)
         begin
            check_cnt++;
            if (o_req_r !== ((issued_tot - freed_d2) < NUM_TAGS))
               report_value("o_req_r", 64'(o_req_r),
                            64'((issued_tot - freed_d2) < NUM_TAGS));
         end
         if (i_req_v && o_req_r)
         begin
            record_command(err_en);
            pending = 0;
         end
         if (o_rsp_v && i_rsp_r && o_rsp_last)
            freed_cnt++;
         #2;
         i_cpl_v    = 1'b0;
         i_cpl_last = 1'b0;
         i_cpl_err  = 1'b0;
         if (!pending && gen < n)
         begin
            r = take_bits(ADDR_W);
            i_req_addr = r[ADDR_W-1:0];
            if (fixed_len)
               i_req_len = len_t'((gen % MAX_CHUNKS) + 1);
            else
            begin
               r = take_bits(2);
               i_req_len = {1'b0, r[1:0]} + 3'd1;
            end
            r = take_bits(ENG_TAG_W);
            i_req_eng_tag = r[ENG_TAG_W-1:0];
            pending = 1;
            gen++;
         end
         i_req_v = pending;
         r = take_bits(1);
         i_cmd_r = stall_en ? r[0] : 1'b1;
         r = take_bits(1);
         i_rsp_r = stall_en ? r[0] : 1'b1;
         // the bus answers one chunk per cycle, from any outstanding read when mixing
         if (act.size() > 0 && !(hold_cpl && (gen < n || pending)))
         begin
            idx = 0;
            if (mix)
            begin
               r = take_bits(4);
               idx = int'(r[3:0]) % act.size();
            end
            rid = act[idx];
            i_cpl_v    = 1'b1;
            i_cpl_tag  = rd_tag[rid];
            i_cpl_data = rd_data[rid][rd_sent[rid]];
            i_cpl_err  = rd_err[rid][rd_sent[rid]];
            i_cpl_last = (rd_sent[rid] == int'(rd_len[rid]) - 1);
            rd_sent[rid]++;
            if (i_cpl_last)
            begin
               exp_order.push_back(rid);
               act.delete(idx);
            end
         end
      end
      i_req_v = 1'b0;
      i_cpl_v = 1'b0;
      i_cmd_r = 1'b1;
      i_rsp_r = 1'b1;
      repeat (4) @(posedge i_clk);
      test_cnt++;
      $display("test %-24s %0d reads, %0d errors", name, n, err_cnt - start_err);
   endtask

   // checks every transferred beat against the reference
   always @(posedge i_clk)
   begin : compare_beats
      int    rid;
      beat_t exp;
      if (i_rst_n && o_rsp_v && i_rsp_r)
      begin
         if (exp_order.size() == 0)
         begin
            $display("response beat arrived with no finished read pending");
            err_cnt++;
         end
         else
         begin
            rid = exp_order[0];
            exp = expect_beat(rid, beat_idx);
            check_cnt++;
            if (o_rsp_eng_tag !== exp.eng_tag)
               report_value("o_rsp_eng_tag", 64'(o_rsp_eng_tag), 64'(exp.eng_tag));
            if (o_rsp_beat !== exp.beat)
               report_value("o_rsp_beat", 64'(o_rsp_beat), 64'(exp.beat));
            if (o_rsp_data !== exp.data)
               report_value("o_rsp_data", o_rsp_data, exp.data);
            if (o_rsp_last !== exp.last)
               report_value("o_rsp_last", 64'(o_rsp_last), 64'(exp.last));
            if (o_rsp_err !== exp.err)
               report_value("o_rsp_err", 64'(o_rsp_err), 64'(exp.err));
            if (exp.last)
            begin
               tag_busy[rd_tag[rid]] = 1'b0;
               void'(exp_order.pop_front());
               beat_idx = 0;
               done_cnt++;
            end
            else
               beat_idx++;
         end
      end
   end

   always @(posedge i_clk)
   begin
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT_CYC)
      begin
         $display("timeout after %0d cycles with %0d reads returned", cycle_cnt, done_cnt);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial
   begin
      tag_busy      = '0;
      i_rst_n       = 1'b0;
      i_req_v       = 1'b0;
      i_req_eng_tag = '0;
      i_req_addr    = '0;
      i_req_len     = 3'd1;
      i_cmd_r       = 1'b1;
      i_cpl_v       = 1'b0;
      i_cpl_tag     = '0;
      i_cpl_data    = '0;
      i_cpl_last    = 1'b0;
      i_cpl_err     = 1'b0;
      i_rsp_r       = 1'b1;
      repeat (4) @(posedge i_clk);
      #2;
      i_rst_n = 1'b1;
      run_test("single reads", 8, 1, 0, 0, 0, 0, 0);
      run_test("error status", 12, 0, 1, 0, 0, 1, 0);
      run_test("interleaved completions", 16, 0, 0, 0, 1, 1, 0);
      run_test("back-pressure", 24, 0, 1, 1, 0, 1, 0);
      run_test("tag reuse", 40, 0, 0, 0, 0, 1, 1);
      $display("tests %0d, reads %0d, checks %0d, errors %0d",
               test_cnt, done_cnt, check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* tb_dma_read_sva.sv */
// interface assertions bound to the read DMA top level
`timescale 1ns/100ps

module tb_dma_read_sva #(
   parameter int DATA_W = 64
) (
   input logic                   i_clk,
   input logic                   i_rst_n,
   input logic                   i_req_v,
   input logic                   o_cmd_v,
   input dma_read_pkg::addr_t    o_cmd_addr,
   input dma_read_pkg::len_t     o_cmd_len,
   input logic                   o_rsp_v,
   input logic                   i_rsp_r,
   input dma_read_pkg::eng_tag_t o_rsp_eng_tag,
   input logic [dma_read_pkg::BEAT_W-1:0] o_rsp_beat,
   input logic [DATA_W-1:0]      o_rsp_data,
   input logic                   o_rsp_last,
   input logic                   o_rsp_err
);

   // a command is only offered while a request is offered
   a_cmd_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_cmd_v |-> i_req_v)
      else $error("o_cmd_v high without i_req_v");

   // a stalled beat keeps every response output unchanged
   a_rsp_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_rsp_v && !i_rsp_r) |=> (o_rsp_v && $stable(o_rsp_eng_tag) && $stable(o_rsp_beat)
         && $stable(o_rsp_data) && $stable(o_rsp_last) && $stable(o_rsp_err)))
      else $error("response outputs changed while stalled");

   a_cmd_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_cmd_v |-> ((o_cmd_len == 3'd1) ? (o_cmd_addr[6:0] == 7'd0) : (o_cmd_addr[8:0] == 9'd0)))
      else $error("o_cmd_addr not aligned for its length");

endmodule

bind dma_read_top tb_dma_read_sva #(.DATA_W(DATA_W)) sva_inst (
   .i_clk         (i_clk),
   .i_rst_n       (i_rst_n),
   .i_req_v       (i_req_v),
   .o_cmd_v       (o_cmd_v),
   .o_cmd_addr    (o_cmd_addr),
   .o_cmd_len     (o_cmd_len),
   .o_rsp_v       (o_rsp_v),
   .i_rsp_r       (i_rsp_r),
   .o_rsp_eng_tag (o_rsp_eng_tag),
   .o_rsp_beat    (o_rsp_beat),
   .o_rsp_data    (o_rsp_data),
   .o_rsp_last    (o_rsp_last),
   .o_rsp_err     (o_rsp_err)
);
